//--- Bender.yml
package:
  name: rv_core

sources:
  - include_dirs:
      - include
    files:
      - source/rv_isa_pkg.sv
      - source/core_pkg.sv
      - source/result_if.sv
      - source/fetch_stage.sv
      - source/decode_stage.sv
      - source/execute_stage.sv
      - source/mem_wb_stage.sv
      - source/rv_core.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/rv_core_assert.sv
      - test/tb_rv_core.sv

//--- include/core_defs.svh
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// datapath and register file sizes
`define XLEN        32
`define REG_ADDR_W  5
`define NUM_REGS    32

`define RESET_VECTOR 32'h0000_0000
`define NOP_INSTR    32'h0000_0013 // addi x0,x0,0
`define INSTR_BYTES  4

`endif

//--- rv_core.f
+incdir+include
source/rv_isa_pkg.sv
source/core_pkg.sv
source/result_if.sv
source/fetch_stage.sv
source/decode_stage.sv
source/execute_stage.sv
source/mem_wb_stage.sv
source/rv_core.sv
test/rv_core_assert.sv
test/tb_rv_core.sv

//--- source/core_pkg.sv
`default_nettype none

`include "core_defs.svh"

package core_pkg;

	typedef logic [`XLEN-1:0]       word_t;
	typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

	typedef enum logic [3:0] {
		ALU_ADD, // zero, so a bubble decodes as add
		ALU_SUB,
		ALU_SLL,
		ALU_SLT,
		ALU_SLTU,
		ALU_XOR,
		ALU_SRL,
		ALU_SRA,
		ALU_OR,
		ALU_AND
	} alu_op_e;

	typedef enum logic {SRC_A_REG, SRC_A_PC} src_a_e;
	typedef enum logic {SRC_B_REG, SRC_B_IMM} src_b_e;

	typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_PC4} wb_sel_e;

	typedef struct packed {
		alu_op_e    alu_op;
		src_a_e     src_a;
		src_b_e     src_b;
		logic       is_branch;
		logic       is_jal;
		logic       is_jalr;
		logic [2:0] br_f3; // raw funct3, decoded in execute
	} ex_ctrl_t;

	typedef struct packed {
		logic is_load;
		logic is_store;
	} mem_ctrl_t;

	typedef struct packed {
		logic    rf_we;
		wb_sel_e wb_sel;
	} wb_ctrl_t;

	typedef enum logic [1:0] {FWD_NONE, FWD_MEM, FWD_WB} fwd_sel_e;

	// bubble bundles, no side effects anywhere
	localparam ex_ctrl_t  EX_CTRL_NOP  = '0;
	localparam mem_ctrl_t MEM_CTRL_NOP = '0;
	localparam wb_ctrl_t  WB_CTRL_NOP  = '0;

endpackage

`default_nettype wire

//--- source/decode_stage.sv
`timescale 1ns/100ps
`default_nettype none

`include "core_defs.svh"

module decode_stage
	import core_pkg::*;
	import rv_isa_pkg::*;
(
	input  logic      clk_i,
	input  logic      reset_i,
	input  word_t     instr_i,
	input  word_t     pc_i,
	input  logic      redirect_i,
	result_if.regfile rf,
	output logic      stall_o,
	output ex_ctrl_t  id_ex_ctrl_o,
	output mem_ctrl_t id_mem_ctrl_o,
	output wb_ctrl_t  id_wb_ctrl_o,
	output reg_addr_t rs1_o,
	output reg_addr_t rs2_o,
	output reg_addr_t rd_o,
	output word_t     rs1_val_o,
	output word_t     rs2_val_o,
	output word_t     imm_o,
	output word_t     pc_o
);
	instr_u    ir;
	word_t     imm_i_t, imm_s_t, imm_b_t, imm_u_t, imm_j_t;
	ex_ctrl_t  ex_c;
	mem_ctrl_t mem_c;
	wb_ctrl_t  wb_c;
	word_t     imm;
	logic      use_rs1, use_rs2, writes_rd;
	reg_addr_t dec_rs1, dec_rs2, dec_rd;
	word_t     regs [`NUM_REGS];

	function automatic alu_op_e alu_from_f3(input alu_f3_e f3, input logic alt);
		alu_op_e op;
		op = ALU_ADD;
		case (f3)
			F3_ADD:  op = alt ? ALU_SUB : ALU_ADD;
			F3_SLL:  op = ALU_SLL;
			F3_SLT:  op = ALU_SLT;
			F3_SLTU: op = ALU_SLTU;
			F3_XOR:  op = ALU_XOR;
			F3_SR:   op = alt ? ALU_SRA : ALU_SRL;
			F3_OR:   op = ALU_OR;
			F3_AND:  op = ALU_AND;
			default: op = ALU_ADD;
		endcase
		return op;
	endfunction

	assign ir = instr_i;

	// immediates, one per format
	assign imm_i_t = {{20{ir.i.imm12[11]}}, ir.i.imm12};
	assign imm_s_t = {{20{ir.r.funct7[6]}}, ir.r.funct7, ir.r.rd};
	assign imm_b_t = {{19{ir.r.funct7[6]}}, ir.r.funct7[6], ir.r.rd[0],
		ir.r.funct7[5:0], ir.r.rd[4:1], 1'b0};
	assign imm_u_t = {ir.r.funct7, ir.r.rs2, ir.r.rs1, ir.r.funct3, 12'b0};
	assign imm_j_t = {{12{ir.i.imm12[11]}}, ir.i.rs1, ir.i.funct3, ir.i.imm12[0],
		ir.i.imm12[10:1], 1'b0};

	always_comb
	begin
		ex_c      = EX_CTRL_NOP;
		mem_c     = MEM_CTRL_NOP;
		wb_c      = WB_CTRL_NOP;
		imm       = '0;
		use_rs1   = 1'b0;
		use_rs2   = 1'b0;
		writes_rd = 1'b0;
		case (ir.r.opcode)
			OPC_OP:
			begin
				ex_c.alu_op = alu_from_f3(alu_f3_e'(ir.r.funct3), ir.r.funct7[5]);
				{use_rs1, use_rs2, writes_rd} = 3'b111;
			end
			OPC_OP_IMM:
			begin
				// bit 30 only selects sra for shifts, addi has no subtract
				ex_c.alu_op = alu_from_f3(alu_f3_e'(ir.i.funct3),
					(ir.i.funct3 == F3_SR) && ir.i.imm12[10]);
				ex_c.src_b = SRC_B_IMM;
				imm = imm_i_t;
				{use_rs1, writes_rd} = 2'b11;
			end
			OPC_LUI:
			begin
				ex_c.src_b = SRC_B_IMM; // x0 + imm
				imm = imm_u_t;
				writes_rd = 1'b1;
			end
			OPC_AUIPC:
			begin
				ex_c.src_a = SRC_A_PC;
				ex_c.src_b = SRC_B_IMM;
				imm = imm_u_t;
				writes_rd = 1'b1;
			end
			OPC_JAL:
			begin
				ex_c.is_jal = 1'b1;
				wb_c.wb_sel = WB_PC4;
				imm = imm_j_t;
				writes_rd = 1'b1;
			end
			OPC_JALR:
			begin
				ex_c.is_jalr = 1'b1;
				ex_c.src_b = SRC_B_IMM;
				wb_c.wb_sel = WB_PC4;
				imm = imm_i_t;
				{use_rs1, writes_rd} = 2'b11;
			end
			OPC_BRANCH:
			begin
				ex_c.is_branch = 1'b1;
				ex_c.br_f3 = ir.r.funct3;
				imm = imm_b_t;
				{use_rs1, use_rs2} = 2'b11;
			end
			OPC_LOAD:
			begin
				mem_c.is_load = 1'b1;
				ex_c.src_b = SRC_B_IMM;
				wb_c.wb_sel = WB_MEM;
				imm = imm_i_t;
				{use_rs1, writes_rd} = 2'b11;
			end
			OPC_STORE:
			begin
				mem_c.is_store = 1'b1;
				ex_c.src_b = SRC_B_IMM;
				imm = imm_s_t;
				{use_rs1, use_rs2} = 2'b11;
			end
			default: ; // unsupported encodings run as bubbles
		endcase
		wb_c.rf_we = writes_rd && (ir.r.rd != '0);
	end

	// unused fields go to x0 so they never match a hazard
	assign dec_rs1 = use_rs1 ? ir.r.rs1 : '0;
	assign dec_rs2 = use_rs2 ? ir.r.rs2 : '0;
	assign dec_rd  = wb_c.rf_we ? ir.r.rd : '0;

	// falling-edge write, decode sees writeback of the same cycle
	always_ff @(negedge clk_i)
	begin
		if (rf.wb_we && (rf.wb_rd != '0))
			regs[rf.wb_rd] <= rf.wb_val;
	end

	// load in ID/EX feeding this instruction
	assign stall_o = id_mem_ctrl_o.is_load && (rd_o != '0) &&
		((rd_o == dec_rs1) || (rd_o == dec_rs2));

	always_ff @(posedge clk_i or negedge reset_i)
	begin
		if (!reset_i)
		begin
			id_ex_ctrl_o  <= EX_CTRL_NOP;
			id_mem_ctrl_o <= MEM_CTRL_NOP;
			id_wb_ctrl_o  <= WB_CTRL_NOP;
			rd_o          <= '0;
		end
		else if (stall_o || redirect_i)
		begin
			id_ex_ctrl_o  <= EX_CTRL_NOP; // bubble
			id_mem_ctrl_o <= MEM_CTRL_NOP;
			id_wb_ctrl_o  <= WB_CTRL_NOP;
			rd_o          <= '0;
		end
		else
		begin
			id_ex_ctrl_o  <= ex_c;
			id_mem_ctrl_o <= mem_c;
			id_wb_ctrl_o  <= wb_c;
			rd_o          <= dec_rd;
		end
	end

	always_ff @(posedge clk_i)
	begin
		rs1_o     <= dec_rs1;
		rs2_o     <= dec_rs2;
		rs1_val_o <= (dec_rs1 == '0) ? '0 : regs[dec_rs1];
		rs2_val_o <= (dec_rs2 == '0) ? '0 : regs[dec_rs2];
		imm_o     <= imm;
		pc_o      <= pc_i;
	end

endmodule

`default_nettype wire

//--- source/execute_stage.sv
`timescale 1ns/100ps
`default_nettype none

`include "core_defs.svh"

module execute_stage
	import core_pkg::*;
	import rv_isa_pkg::*;
(
	input  logic      clk_i,
	input  logic      reset_i,
	input  ex_ctrl_t  id_ex_ctrl_i,
	input  mem_ctrl_t id_mem_ctrl_i,
	input  wb_ctrl_t  id_wb_ctrl_i,
	input  reg_addr_t rs1_i,
	input  reg_addr_t rs2_i,
	input  reg_addr_t rd_i,
	input  word_t     rs1_val_i,
	input  word_t     rs2_val_i,
	input  word_t     imm_i,
	input  word_t     pc_i,
	result_if.forward fwd,
	output logic      redirect_o,
	output word_t     target_o,
	output word_t     data_addr_o,
	output word_t     data_o,
	output logic      data_we_o,
	output mem_ctrl_t exmem_mem_ctrl_o,
	output wb_ctrl_t  exmem_wb_ctrl_o,
	output reg_addr_t exmem_rd_o,
	output word_t     exmem_alu_o,
	output word_t     exmem_pc4_o
);
	fwd_sel_e sel_a, sel_b;
	word_t    rs1_fwd, rs2_fwd;
	word_t    op_a, op_b;
	word_t    alu_res;
	logic     eq, lt_s, lt_u;
	logic     taken;

	// memory stage is younger, so it wins over writeback
	function automatic fwd_sel_e fwd_pick(input reg_addr_t rs);
		if (rs == '0)
			return FWD_NONE;
		else if (fwd.mem_we && (fwd.mem_rd == rs))
			return FWD_MEM;
		else if (fwd.wb_we && (fwd.wb_rd == rs))
			return FWD_WB;
		else
			return FWD_NONE;
	endfunction

	function automatic word_t fwd_mux(input fwd_sel_e sel, input word_t reg_val);
		case (sel)
			FWD_MEM: return fwd.mem_val;
			FWD_WB:  return fwd.wb_val;
			default: return reg_val;
		endcase
	endfunction

	always_comb
	begin
		sel_a   = fwd_pick(rs1_i);
		sel_b   = fwd_pick(rs2_i);
		rs1_fwd = fwd_mux(sel_a, rs1_val_i);
		rs2_fwd = fwd_mux(sel_b, rs2_val_i);
	end

	assign op_a = (id_ex_ctrl_i.src_a == SRC_A_PC) ? pc_i : rs1_fwd;
	assign op_b = (id_ex_ctrl_i.src_b == SRC_B_IMM) ? imm_i : rs2_fwd;

	// compares shared by slt/sltu and the branches
	assign eq   = (op_a == op_b);
	assign lt_s = ($signed(op_a) < $signed(op_b));
	assign lt_u = (op_a < op_b);

	always_comb
	begin
		case (id_ex_ctrl_i.alu_op)
			ALU_SUB:  alu_res = op_a - op_b;
			ALU_SLL:  alu_res = op_a << op_b[4:0];
			ALU_SLT:  alu_res = word_t'(lt_s);
			ALU_SLTU: alu_res = word_t'(lt_u);
			ALU_XOR:  alu_res = op_a ^ op_b;
			ALU_SRL:  alu_res = op_a >> op_b[4:0];
			ALU_SRA:  alu_res = $signed(op_a) >>> op_b[4:0];
			ALU_OR:   alu_res = op_a | op_b;
			ALU_AND:  alu_res = op_a & op_b;
			default:  alu_res = op_a + op_b;
		endcase
	end

	always_comb
	begin
		case (branch_f3_e'(id_ex_ctrl_i.br_f3))
			BEQ:     taken = eq;
			BNE:     taken = !eq;
			BLT:     taken = lt_s;
			BGE:     taken = !lt_s;
			BLTU:    taken = lt_u;
			BGEU:    taken = !lt_u;
			default: taken = 1'b0;
		endcase
	end

	assign redirect_o = id_ex_ctrl_i.is_jal || id_ex_ctrl_i.is_jalr ||
		(id_ex_ctrl_i.is_branch && taken);
	assign target_o = id_ex_ctrl_i.is_jalr ? {alu_res[`XLEN-1:1], 1'b0} : pc_i + imm_i;

	// data memory request leaves in the execute cycle
	assign data_addr_o = alu_res;
	assign data_o      = rs2_fwd;
	assign data_we_o   = id_mem_ctrl_i.is_store;

	always_ff @(posedge clk_i or negedge reset_i)
	begin
		if (!reset_i)
		begin
			exmem_mem_ctrl_o <= MEM_CTRL_NOP;
			exmem_wb_ctrl_o  <= WB_CTRL_NOP;
			exmem_rd_o       <= '0;
		end
		else
		begin
			exmem_mem_ctrl_o <= id_mem_ctrl_i;
			exmem_wb_ctrl_o  <= id_wb_ctrl_i;
			exmem_rd_o       <= rd_i;
		end
	end

	always_ff @(posedge clk_i)
	begin
		exmem_alu_o <= alu_res;
		exmem_pc4_o <= pc_i + `INSTR_BYTES; // link value
	end

endmodule

`default_nettype wire

//--- source/fetch_stage.sv
`timescale 1ns/100ps
`default_nettype none

`include "core_defs.svh"

module fetch_stage
	import core_pkg::*;
	import rv_isa_pkg::*;
(
	input  logic  clk_i,
	input  logic  reset_i,
	input  logic  stall_i,
	input  logic  redirect_i,
	input  word_t target_i,
	input  word_t instr_i,      // belongs to pc_q
	output word_t instr_addr_o,
	output word_t ifid_instr_o,
	output word_t ifid_pc_o
);
	word_t  pc_q;
	word_t  next_pc;
	logic   run_q;  // low until the reset vector has been requested
	instr_u ifid_q;

	always_comb
	begin
		if (redirect_i)
			next_pc = target_i;
		else if (stall_i || !run_q)
			next_pc = pc_q; // hold
		else
			next_pc = pc_q + `INSTR_BYTES;
	end

	assign instr_addr_o = next_pc;
	assign ifid_instr_o = ifid_q;

	always_ff @(posedge clk_i or negedge reset_i)
	begin
		if (!reset_i)
		begin
			pc_q      <= `RESET_VECTOR;
			run_q     <= 1'b0;
			ifid_q    <= `NOP_INSTR;
			ifid_pc_o <= `RESET_VECTOR;
		end
		else
		begin
			run_q <= 1'b1;
			pc_q  <= next_pc;
			// first cycle has no valid instruction yet
			if (redirect_i || !run_q)
				ifid_q <= `NOP_INSTR;
			else if (!stall_i)
			begin
				ifid_q    <= instr_i;
				ifid_pc_o <= pc_q;
			end
		end
	end

endmodule

`default_nettype wire

//--- source/mem_wb_stage.sv
`timescale 1ns/100ps
`default_nettype none

module mem_wb_stage
	import core_pkg::*;
(
	input  logic       clk_i,
	input  logic       reset_i,
	input  mem_ctrl_t  exmem_mem_ctrl_i,
	input  wb_ctrl_t   exmem_wb_ctrl_i,
	input  reg_addr_t  exmem_rd_i,
	input  word_t      exmem_alu_i,
	input  word_t      exmem_pc4_i,
	input  word_t      data_i,      // load data, one cycle after the request
	result_if.producer res
);
	wb_ctrl_t  memwb_wb_q;
	reg_addr_t memwb_rd_q;
	word_t     memwb_alu_q;
	word_t     memwb_load_q;
	word_t     memwb_pc4_q;
	word_t     wb_val;

	// memory-stage result for forwarding, loads are held back by the stall
	assign res.mem_rd  = exmem_rd_i;
	assign res.mem_we  = exmem_wb_ctrl_i.rf_we && !exmem_mem_ctrl_i.is_load;
	assign res.mem_val = (exmem_wb_ctrl_i.wb_sel == WB_PC4) ? exmem_pc4_i : exmem_alu_i;

	always_ff @(posedge clk_i or negedge reset_i)
	begin
		if (!reset_i)
		begin
			memwb_wb_q <= WB_CTRL_NOP;
			memwb_rd_q <= '0;
		end
		else
		begin
			memwb_wb_q <= exmem_wb_ctrl_i;
			memwb_rd_q <= exmem_rd_i;
		end
	end

	always_ff @(posedge clk_i)
	begin
		memwb_alu_q  <= exmem_alu_i;
		memwb_load_q <= data_i;
		memwb_pc4_q  <= exmem_pc4_i;
	end

	always_comb
	begin
		case (memwb_wb_q.wb_sel)
			WB_MEM:  wb_val = memwb_load_q;
			WB_PC4:  wb_val = memwb_pc4_q;
			default: wb_val = memwb_alu_q;
		endcase
	end

	assign res.wb_rd  = memwb_rd_q;
	assign res.wb_we  = memwb_wb_q.rf_we;
	assign res.wb_val = wb_val;

endmodule

`default_nettype wire

//--- source/result_if.sv
`timescale 1ns/100ps
`default_nettype none

`include "core_defs.svh"

// results of the memory and writeback stages, seen by decode and execute
interface result_if;
	logic [`REG_ADDR_W-1:0] mem_rd;
	logic                   mem_we;  // low for loads, their data is not ready yet
	logic [`XLEN-1:0]       mem_val;
	logic [`REG_ADDR_W-1:0] wb_rd;
	logic                   wb_we;
	logic [`XLEN-1:0]       wb_val;

	modport producer (output mem_rd, mem_we, mem_val, wb_rd, wb_we, wb_val);
	modport forward  (input mem_rd, mem_we, mem_val, wb_rd, wb_we, wb_val);
	modport regfile  (input wb_rd, wb_we, wb_val);
endinterface

`default_nettype wire

//--- source/rv_core.sv
`timescale 1ns/100ps
`default_nettype none

module rv_core
	import core_pkg::*;
(
	input  logic  clk_i,
	input  logic  reset_i,
	output word_t instr_addr_o,
	input  word_t instr_i,
	output word_t data_addr_o,
	output word_t data_o,
	input  word_t data_i,
	output logic  data_we_o
);
	logic      stall, redirect;
	word_t     target;
	word_t     ifid_instr, ifid_pc;
	ex_ctrl_t  idex_ex_ctrl;
	mem_ctrl_t idex_mem_ctrl, exmem_mem_ctrl;
	wb_ctrl_t  idex_wb_ctrl, exmem_wb_ctrl;
	reg_addr_t idex_rs1, idex_rs2, idex_rd, exmem_rd;
	word_t     idex_rs1_val, idex_rs2_val, idex_imm, idex_pc;
	word_t     exmem_alu, exmem_pc4;

	result_if res_bus ();

	fetch_stage u_fetch (
		.clk_i        (clk_i),
		.reset_i      (reset_i),
		.stall_i      (stall),
		.redirect_i   (redirect),
		.target_i     (target),
		.instr_i      (instr_i),
		.instr_addr_o (instr_addr_o),
		.ifid_instr_o (ifid_instr),
		.ifid_pc_o    (ifid_pc)
	);

	decode_stage u_decode (
		.clk_i         (clk_i),
		.reset_i       (reset_i),
		.instr_i       (ifid_instr),
		.pc_i          (ifid_pc),
		.redirect_i    (redirect),
		.rf            (res_bus.regfile),
		.stall_o       (stall),
		.id_ex_ctrl_o  (idex_ex_ctrl),
		.id_mem_ctrl_o (idex_mem_ctrl),
		.id_wb_ctrl_o  (idex_wb_ctrl),
		.rs1_o         (idex_rs1),
		.rs2_o         (idex_rs2),
		.rd_o          (idex_rd),
		.rs1_val_o     (idex_rs1_val),
		.rs2_val_o     (idex_rs2_val),
		.imm_o         (idex_imm),
		.pc_o          (idex_pc)
	);

	execute_stage u_execute (
		.clk_i            (clk_i),
		.reset_i          (reset_i),
		.id_ex_ctrl_i     (idex_ex_ctrl),
		.id_mem_ctrl_i    (idex_mem_ctrl),
		.id_wb_ctrl_i     (idex_wb_ctrl),
		.rs1_i            (idex_rs1),
		.rs2_i            (idex_rs2),
		.rd_i             (idex_rd),
		.rs1_val_i        (idex_rs1_val),
		.rs2_val_i        (idex_rs2_val),
		.imm_i            (idex_imm),
		.pc_i             (idex_pc),
		.fwd              (res_bus.forward),
		.redirect_o       (redirect),
		.target_o         (target),
		.data_addr_o      (data_addr_o),
		.data_o           (data_o),
		.data_we_o        (data_we_o),
		.exmem_mem_ctrl_o (exmem_mem_ctrl),
		.exmem_wb_ctrl_o  (exmem_wb_ctrl),
		.exmem_rd_o       (exmem_rd),
		.exmem_alu_o      (exmem_alu),
		.exmem_pc4_o      (exmem_pc4)
	);

	mem_wb_stage u_mem_wb (
		.clk_i            (clk_i),
		.reset_i          (reset_i),
		.exmem_mem_ctrl_i (exmem_mem_ctrl),
		.exmem_wb_ctrl_i  (exmem_wb_ctrl),
		.exmem_rd_i       (exmem_rd),
		.exmem_alu_i      (exmem_alu),
		.exmem_pc4_i      (exmem_pc4),
		.data_i           (data_i),
		.res              (res_bus.producer)
	);

endmodule

`default_nettype wire

//--- source/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

	// major opcodes of the supported subset
	typedef enum logic [6:0] {
		OPC_OP     = 7'b0110011,
		OPC_OP_IMM = 7'b0010011,
		OPC_LUI    = 7'b0110111,
		OPC_AUIPC  = 7'b0010111,
		OPC_JAL    = 7'b1101111,
		OPC_JALR   = 7'b1100111,
		OPC_BRANCH = 7'b1100011,
		OPC_LOAD   = 7'b0000011,
		OPC_STORE  = 7'b0100011
	} opcode_e;

	typedef enum logic [2:0] {
		BEQ  = 3'b000,
		BNE  = 3'b001,
		BLT  = 3'b100,
		BGE  = 3'b101,
		BLTU = 3'b110,
		BGEU = 3'b111
	} branch_f3_e;

	typedef enum logic [2:0] {
		F3_ADD  = 3'b000, // add, sub
		F3_SLL  = 3'b001,
		F3_SLT  = 3'b010,
		F3_SLTU = 3'b011,
		F3_XOR  = 3'b100,
		F3_SR   = 3'b101, // srl, sra
		F3_OR   = 3'b110,
		F3_AND  = 3'b111
	} alu_f3_e;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		opcode_e    opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm12;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		opcode_e     opcode;
	} i_fmt_t;

	// same instruction word, register view and immediate view
	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
	} instr_u;

endpackage

`default_nettype wire

//--- test/rv_core_assert.sv
`timescale 1ns/100ps
`default_nettype none

module rv_core_assert
	import core_pkg::*;
(
	input logic      clk_i,
	input logic      reset_i,
	input logic      data_we_i,
	input logic      redirect_i,
	input word_t     target_i,
	input logic      rf_we_i,
	input reg_addr_t rf_rd_i
);
	int fail_count = 0; // summed into the testbench result

	// store strobe is always driven once out of reset
	assert property (@(posedge clk_i) disable iff (!reset_i) !$isunknown(data_we_i))
	else
	begin
		fail_count++;
		$error("data_we_o is unknown after reset");
	end

	assert property (@(posedge clk_i) disable iff (!reset_i)
		redirect_i |-> (target_i[1:0] == 2'b00))
	else
	begin
		fail_count++;
		$error("redirect target %h is not word aligned", target_i);
	end

	// x0 keeps zero since no writeback ever addresses it
	assert property (@(posedge clk_i) disable iff (!reset_i)
		rf_we_i |-> (rf_rd_i != '0))
	else
	begin
		fail_count++;
		$error("register file write addressed x0");
	end

endmodule

bind rv_core rv_core_assert u_assert (
	.clk_i      (clk_i),
	.reset_i    (reset_i),
	.data_we_i  (data_we_o),
	.redirect_i (redirect),
	.target_i   (target),
	.rf_we_i    (res_bus.wb_we),
	.rf_rd_i    (res_bus.wb_rd)
);

`default_nettype wire

//--- test/tb_rv_core.sv
`timescale 1ns/100ps
`default_nettype none

`include "core_defs.svh"

module tb_rv_core
	import core_pkg::*;
	import rv_isa_pkg::*;
();
	localparam int    BODY_LEN       = 60;
	localparam int    PROLOGUE_LEN   = 31;  // base register plus x1..x30
	localparam int    PROG_LEN       = PROLOGUE_LEN + BODY_LEN + 1;
	localparam int    TIMEOUT_CYCLES = 2000;
	localparam int    DATA_WORDS     = 64;
	localparam word_t DATA_BASE      = 32'h0000_1000; // held in x31
	localparam word_t SELF_LOOP      = 32'h0000_006f; // jal x0,0

	logic   clk;
	logic   reset_n;
	word_t  instr_addr;
	word_t  instr;
	word_t  data_addr;
	word_t  data_wdata;
	word_t  data_rdata;
	logic   data_we;
	integer seed;
	word_t  prog [PROG_LEN];
	word_t  ram [DATA_WORDS];
	word_t  exp_addr [$];
	word_t  exp_data [$];
	int     stores_seen;
	int     value_errors;
	int     other_errors;
	int     cycles;

	rv_core dut (
		.clk_i        (clk),
		.reset_i      (reset_n),
		.instr_addr_o (instr_addr),
		.instr_i      (instr),
		.data_addr_o  (data_addr),
		.data_o       (data_wdata),
		.data_i       (data_rdata),
		.data_we_o    (data_we)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	function automatic int unsigned rand_below(input int unsigned n);
		return {$random(seed)} % n;
	endfunction

	// initial data contents, every address bit takes part
	function automatic word_t fill_word(input word_t addr);
		return (addr * 32'h9e37_79b1) ^ {addr[15:0], addr[31:16]};
	endfunction

	function automatic logic in_region(input word_t addr);
		return (addr >= DATA_BASE) && (addr < DATA_BASE + DATA_WORDS * 4) &&
			(addr[1:0] == 2'b00);
	endfunction

	function automatic int ram_index(input word_t addr);
		return int'((addr - DATA_BASE) >> 2);
	endfunction

	function automatic word_t prog_word(input word_t addr);
		if (addr[31:2] < PROG_LEN)
			return prog[addr[31:2]];
		return `NOP_INSTR; // past the end
	endfunction

	function automatic word_t alu_ref(input logic [2:0] f3, input logic alt,
		input word_t a, input word_t b);
		case (f3)
			3'd0: return alt ? a - b : a + b;
			3'd1: return a << b[4:0];
			3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'd3: return (a < b) ? 32'd1 : 32'd0;
			3'd4: return a ^ b;
			3'd5:
			begin
				if (alt)
					return $signed(a) >>> b[4:0];
				return a >> b[4:0];
			end
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic branch_ref(input logic [2:0] f3, input word_t a, input word_t b);
		case (f3)
			3'd0: return a == b;
			3'd1: return a != b;
			3'd4: return $signed(a) < $signed(b);
			3'd5: return $signed(a) >= $signed(b);
			3'd6: return a < b;
			default: return a >= b;
		endcase
	endfunction

	task automatic check_word(input word_t actual, input word_t expected, input string name);
		if (actual !== expected)
		begin
			value_errors++;
			$display("** Error at %0t: %s = %h, expected %h", $time, name, actual, expected);
		end
	endtask

	task automatic check_bit(input logic actual, input logic expected, input string name);
		if (actual !== expected)
		begin
			value_errors++;
			$display("** Error at %0t: %s = %b, expected %b", $time, name, actual, expected);
		end
	endtask

	task automatic gen_program();
		int unsigned kind;
		int unsigned tgt;
		int          i;
		word_t       rnd;
		logic [4:0]  rd, rs1, rs2, last_rd;
		logic [2:0]  f3;
		logic [11:0] imm;
		logic [12:0] boff;
		logic [20:0] joff;
		logic        alt;
		last_rd = 5'd1;
		prog[0] = {20'h00001, 5'd31, OPC_LUI};
		for (i = 1; i < PROLOGUE_LEN; i++)
		begin
			rnd = $random(seed);
			prog[i] = {rnd[11:0], 5'd0, 3'b000, 5'(i), OPC_OP_IMM}; // defined start values
		end
		for (i = PROLOGUE_LEN; i < PROG_LEN - 1; i++)
		begin
			kind = rand_below(16);
			rnd  = $random(seed);
			rd   = 5'(rand_below(31)); // x31 stays the data base
			rs1  = (rand_below(3) != 0) ? last_rd : 5'(rand_below(32));
			rs2  = 5'(rand_below(32));
			f3   = 3'(rand_below(8));
			imm  = 12'(rand_below(DATA_WORDS) * 4);
			tgt  = i + 2 + rand_below(3);
			if (tgt > PROG_LEN - 1)
				tgt = PROG_LEN - 1;
			case (kind)
				0, 1, 2, 3:
				begin
					alt = ((f3 == 3'd0) || (f3 == 3'd5)) && (rand_below(2) == 1);
					prog[i] = {alt ? 7'h20 : 7'h00, rs2, rs1, f3, rd, OPC_OP};
					last_rd = rd;
				end
				4, 5, 6:
				begin
					if (f3 == 3'd1)
						imm = {7'h00, rs2};
					else if (f3 == 3'd5)
						imm = {(rand_below(2) == 1) ? 7'h20 : 7'h00, rs2};
					else
						imm = rnd[11:0];
					prog[i] = {imm, rs1, f3, rd, OPC_OP_IMM};
					last_rd = rd;
				end
				7: prog[i] = {rnd[31:12], rd, OPC_LUI};
				8: prog[i] = {rnd[31:12], rd, OPC_AUIPC};
				9:
				begin
					prog[i] = {imm, 5'd31, 3'b010, rd, OPC_LOAD};
					last_rd = rd;
				end
				10, 11:
				begin
					rs2 = (rand_below(2) == 1) ? last_rd : rs2; // often the latest result
					prog[i] = {imm[11:5], rs2, 5'd31, 3'b010, imm[4:0], OPC_STORE};
				end
				12, 13:
				begin
					if ((f3 == 3'd2) || (f3 == 3'd3))
						f3 = f3 + 3'd4;
					boff = 13'((tgt - i) * 4);
					prog[i] = {boff[12], boff[10:5], rs2, rs1, f3, boff[4:1], boff[11],
						OPC_BRANCH};
				end
				14:
				begin
					joff = 21'((tgt - i) * 4);
					prog[i] = {joff[20], joff[10:1], joff[11], joff[19:12], rd, OPC_JAL};
					last_rd = rd;
				end
				default:
				begin
					imm = 12'(tgt * 4 + 1); // odd on purpose, bit 0 gets cleared
					prog[i] = {imm, 5'd0, 3'b000, rd, OPC_JALR};
					last_rd = rd;
				end
			endcase
		end
		prog[PROG_LEN - 1] = SELF_LOOP;
	endtask

	// instruction level reference, one instruction per step
	task automatic run_model();
		word_t      xr [32];
		word_t      mem [DATA_WORDS];
		word_t      pc, ins, a, b, ea, res, next;
		word_t      imm_i, imm_s, imm_b, imm_j;
		logic [4:0] rd;
		logic [2:0] f3;
		logic       wr;
		int         steps;
		foreach (xr[r])
			xr[r] = '0;
		foreach (mem[w])
			mem[w] = fill_word(DATA_BASE + w * 4);
		pc    = `RESET_VECTOR;
		steps = 0;
		while ((prog_word(pc) != SELF_LOOP) && (steps < 4 * PROG_LEN))
		begin
			ins   = prog_word(pc);
			rd    = ins[11:7];
			f3    = ins[14:12];
			a     = xr[ins[19:15]];
			b     = xr[ins[24:20]];
			imm_i = {{20{ins[31]}}, ins[31:20]};
			imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
			imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
			imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
			next  = pc + 4;
			res   = '0;
			wr    = 1'b1;
			case (ins[6:0])
				OPC_OP:     res = alu_ref(f3, ins[30], a, b);
				OPC_OP_IMM: res = alu_ref(f3, ins[30] && (f3 == 3'd5), a, imm_i);
				OPC_LUI:    res = {ins[31:12], 12'b0};
				OPC_AUIPC:  res = pc + {ins[31:12], 12'b0};
				OPC_JAL:
				begin
					res  = pc + 4;
					next = pc + imm_j;
				end
				OPC_JALR:
				begin
					res  = pc + 4;
					next = (a + imm_i) & ~32'd1;
				end
				OPC_LOAD:   res = mem[ram_index(a + imm_i)];
				OPC_BRANCH:
				begin
					wr = 1'b0;
					if (branch_ref(f3, a, b))
						next = pc + imm_b;
				end
				OPC_STORE:
				begin
					wr = 1'b0;
					ea = a + imm_s;
					mem[ram_index(ea)] = b;
					exp_addr.push_back(ea);
					exp_data.push_back(b);
				end
				default: wr = 1'b0;
			endcase
			if (wr && (rd != 5'd0))
				xr[rd] = res;
			pc = next;
			steps++;
		end
		if (prog_word(pc) != SELF_LOOP)
		begin
			other_errors++;
			$display("reference model never reached the final loop, stopped at pc %h", pc);
		end
	endtask

	task automatic record_store(input word_t addr, input word_t data);
		if (stores_seen < exp_addr.size())
		begin
			check_word(addr, exp_addr[stores_seen], "data_addr_o");
			check_word(data, exp_data[stores_seen], "data_o");
		end
		else
		begin
			other_errors++;
			$display("unexpected store to %h at %0t, the model has only %0d stores",
				addr, $time, exp_addr.size());
		end
		if (in_region(addr))
			ram[ram_index(addr)] = data;
		stores_seen++;
	endtask

	// synchronous instruction memory
	always @(posedge clk)
	begin : instr_mem
		word_t addr;
		addr = instr_addr;
		#1;
		instr = prog_word(addr);
	end

	// store seen in execute, load data one cycle later
	always @(posedge clk)
	begin : data_mem
		word_t addr;
		addr = data_addr;
		if (reset_n && data_we)
			record_store(addr, data_wdata);
		#1;
		data_rdata = in_region(addr) ? ram[ram_index(addr)] : fill_word(addr);
	end

	initial
	begin
		reset_n      = 1'b0;
		instr        = `NOP_INSTR;
		data_rdata   = '0;
		seed         = 32'h7ccd;
		stores_seen  = 0;
		value_errors = 0;
		other_errors = 0;
		gen_program();
		run_model();
		foreach (ram[w])
			ram[w] = fill_word(DATA_BASE + w * 4);

		@(posedge clk);
		#3;
		check_bit(data_we, 1'b0, "data_we_o");
		check_word(instr_addr, `RESET_VECTOR, "instr_addr_o");
		@(posedge clk);
		#1 reset_n = 1'b1;
		#2;
		check_bit(data_we, 1'b0, "data_we_o");
		check_word(instr_addr, `RESET_VECTOR, "instr_addr_o");

		cycles = 0;
		while ((stores_seen < exp_addr.size()) && (cycles < TIMEOUT_CYCLES))
		begin
			@(posedge clk);
			cycles++;
		end
		if (stores_seen < exp_addr.size())
		begin
			other_errors++;
			$display("timeout after %0d cycles, only %0d of %0d stores seen",
				cycles, stores_seen, exp_addr.size());
		end

		// final loop keeps spinning, no store may follow
		cycles = 0;
		while (cycles < 20)
		begin
			@(posedge clk);
			cycles++;
		end

		$display("errors: %0d value, %0d other, %0d assertion (%0d stores checked)",
			value_errors, other_errors, dut.u_assert.fail_count, stores_seen);
		if ((value_errors + other_errors + dut.u_assert.fail_count) == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire
